// ==== src/corr_pkg.sv ====
// ##########################################################
// shared sizes, enums and structs for the correlator
// counters are 16 bit and never saturate, windows are at most
// 256 ticks long
// ##########################################################

package corr_pkg;

	// ##########################################################
	// sizes
	// ##########################################################
	localparam int num_ch = 4;
	localparam int num_lags = 2;
	localparam int num_pairs = 6;
	localparam int count_w = 16;
	localparam int num_words = num_ch + num_ch * num_lags + num_pairs;
	localparam int packet_bytes = 2 * num_words + 3;  // header, divisor, payload, checksum
	localparam logic [7:0] sync_byte = 8'hA5;

	// channel pair order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
	localparam int pair_a [num_pairs] = '{0, 0, 0, 1, 1, 2};
	localparam int pair_b [num_pairs] = '{1, 2, 3, 2, 3, 3};

	// ##########################################################
	// enums
	// ##########################################################
	typedef enum logic [2:0] {
		op_rate = 3'b001,    // sample period
		op_invert = 3'b010,  // line invert mask
		op_start = 3'b011,   // open a window
		op_clear = 3'b100    // abort window or packet
	} opcode_e;

	typedef enum logic [2:0] {
		idle,
		header,
		divisor,
		payload,
		checksum
	} frame_state_e;

	// ##########################################################
	// structs
	// ##########################################################
	typedef struct packed {
		logic [4:0] div_code;  // period is div_code + 1 cycles
		logic [3:0] invert;    // one bit per line
	} sample_cfg_t;

	typedef struct packed {
		logic start;           // one cycle
		logic abort;           // one cycle
		logic [4:0] len_code;  // (len_code + 1) * 8 ticks
	} window_ctl_t;

endpackage

// ==== src/cmd_parser.sv ====
// ##########################################################
// command byte decoder, opcode in bits 7..5, argument in 4..0
// start and abort are combinational from the strobed byte
// only op_clear is accepted while busy
// ##########################################################

module cmd_parser (
	input logic intclk,
	input logic rst_n,
	input logic [7:0] rx_data,
	input logic rx_valid,
	input logic busy,
	output corr_pkg::sample_cfg_t cfg,
	output corr_pkg::window_ctl_t win
);

	corr_pkg::opcode_e opcode;
	logic [4:0] arg;

	assign opcode = corr_pkg::opcode_e'(rx_data[7:5]);
	assign arg = rx_data[4:0];

	// ##########################################################
	// configuration registers
	// ##########################################################
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			cfg <= '0;
		end else if (rx_valid && !busy) begin
			case (opcode)
				corr_pkg::op_rate: cfg.div_code <= arg;
				corr_pkg::op_invert: cfg.invert <= arg[3:0];
				default: ;  // other codes leave the config alone
			endcase
		end
	end

	// ##########################################################
	// window control pulses
	// ##########################################################
	always_comb begin
		win = '0;
		win.len_code = arg;
		if (rx_valid) begin
			win.start = (opcode == corr_pkg::op_start) && !busy;
			win.abort = (opcode == corr_pkg::op_clear);
		end
	end

	assert property (@(posedge intclk) disable iff (!rst_n)
		!(win.start && win.abort));

	// a start always opens a window
	assert property (@(posedge intclk) disable iff (!rst_n)
		win.start |=> busy);

endmodule

// ==== src/sample_clock.sv ====
// ##########################################################
// sample tick generator, first tick one cycle after start
// window_done is raised together with the last tick
// ##########################################################

module sample_clock (
	input logic intclk,
	input logic rst_n,
	input corr_pkg::sample_cfg_t cfg,
	input corr_pkg::window_ctl_t win,
	output logic tick,
	output logic window_active,
	output logic window_done
);

	logic [4:0] period_cnt;
	logic [7:0] tick_cnt;   // index of the tick being issued
	logic [4:0] len_code;
	logic [7:0] last_tick;

	assign last_tick = {len_code, 3'b111};  // (len + 1) * 8 - 1

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			tick <= 1'b0;
			window_active <= 1'b0;
			window_done <= 1'b0;
			period_cnt <= '0;
			tick_cnt <= '0;
			len_code <= '0;
		end else if (win.abort) begin
			tick <= 1'b0;
			window_active <= 1'b0;
			window_done <= 1'b0;
			period_cnt <= '0;
			tick_cnt <= '0;
		end else if (win.start) begin
			tick <= 1'b1;           // first tick right away
			window_active <= 1'b1;
			window_done <= 1'b0;
			period_cnt <= '0;
			tick_cnt <= '0;
			len_code <= win.len_code;
		end else if (window_done) begin
			tick <= 1'b0;
			window_active <= 1'b0;
			window_done <= 1'b0;
		end else if (window_active) begin
			if (period_cnt == cfg.div_code) begin
				tick <= 1'b1;
				period_cnt <= '0;
				tick_cnt <= tick_cnt + 8'd1;
				window_done <= (tick_cnt + 8'd1 == last_tick);
			end else begin
				tick <= 1'b0;
				period_cnt <= period_cnt + 5'd1;
			end
		end
	end

	assert property (@(posedge intclk) disable iff (!rst_n)
		window_done |-> tick && window_active);

endmodule

// ==== src/channel_frontend.sv ====
// ##########################################################
// one detector line, inversion, lag delay line and counter
// line is taken as synchronous to intclk
// ##########################################################

module channel_frontend (
	input logic intclk,
	input logic rst_n,
	input logic line,
	input logic invert,
	input logic tick,
	input logic clear,
	output logic sample,
	output logic [corr_pkg::num_lags-1:0] taps,
	output logic [corr_pkg::count_w-1:0] count
);

	assign sample = line ^ invert;  // value taken on the tick edge

	// ##########################################################
	// delay line, taps[0] is the previous tick
	// ##########################################################
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			taps <= '0;
		end else if (clear) begin
			taps <= '0;
		end else if (tick) begin
			taps <= {taps[corr_pkg::num_lags-2:0], sample};
		end
	end

	// ##########################################################
	// pulse counter
	// ##########################################################
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (tick && sample) begin
			count <= count + 1'b1;
		end
	end

endmodule

// ==== src/lag_correlator.sv ====
// ##########################################################
// auto products at lags 1..num_lags and zero lag cross
// products, auto index is channel * num_lags + lag - 1
// ##########################################################

module lag_correlator (
	input logic intclk,
	input logic rst_n,
	input logic tick,
	input logic clear,
	input logic [corr_pkg::num_ch-1:0] samples,
	input logic [corr_pkg::num_ch-1:0][corr_pkg::num_lags-1:0] taps,
	output logic [corr_pkg::num_ch*corr_pkg::num_lags-1:0][corr_pkg::count_w-1:0] auto_counts,
	output logic [corr_pkg::num_pairs-1:0][corr_pkg::count_w-1:0] cross_counts
);

	logic [corr_pkg::num_ch*corr_pkg::num_lags-1:0] auto_hit;
	logic [corr_pkg::num_pairs-1:0] cross_hit;

	for (genvar c = 0; c < corr_pkg::num_ch; c++) begin : g_auto_ch
		for (genvar k = 0; k < corr_pkg::num_lags; k++) begin : g_auto_lag
			assign auto_hit[c*corr_pkg::num_lags+k] = samples[c] & taps[c][k];
		end
	end

	for (genvar p = 0; p < corr_pkg::num_pairs; p++) begin : g_pair
		assign cross_hit[p] = samples[corr_pkg::pair_a[p]] & samples[corr_pkg::pair_b[p]];
	end

	// ##########################################################
	// product counters
	// ##########################################################
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			auto_counts <= '0;
			cross_counts <= '0;
		end else if (clear) begin
			auto_counts <= '0;
			cross_counts <= '0;
		end else if (tick) begin
			for (int i = 0; i < corr_pkg::num_ch * corr_pkg::num_lags; i++) begin
				auto_counts[i] <= auto_counts[i] + corr_pkg::count_w'(auto_hit[i]);
			end
			for (int p = 0; p < corr_pkg::num_pairs; p++) begin
				cross_counts[p] <= cross_counts[p] + corr_pkg::count_w'(cross_hit[p]);
			end
		end
	end

endmodule

// ==== src/packet_framer.sv ====
// ##########################################################
// result packet, sync, divisor code, 18 words high byte
// first, then the XOR of all earlier bytes
// one byte per cycle, no back-pressure
// ##########################################################

module packet_framer (
	input logic intclk,
	input logic rst_n,
	input logic window_done,
	input logic abort,
	input corr_pkg::sample_cfg_t cfg,
	input logic [corr_pkg::num_ch-1:0][corr_pkg::count_w-1:0] pulse_counts,
	input logic [corr_pkg::num_ch*corr_pkg::num_lags-1:0][corr_pkg::count_w-1:0] auto_counts,
	input logic [corr_pkg::num_pairs-1:0][corr_pkg::count_w-1:0] cross_counts,
	output logic [7:0] tx_data,
	output logic tx_valid
);

	corr_pkg::frame_state_e state;
	logic [5:0] byte_idx;
	logic [7:0] chk;
	logic [corr_pkg::num_words-1:0][corr_pkg::count_w-1:0] word_bus;
	logic [corr_pkg::num_words-1:0][corr_pkg::count_w-1:0] words;
	logic [corr_pkg::count_w-1:0] cur_word;

	assign word_bus = {cross_counts, auto_counts, pulse_counts};  // word 0 is pulse 0

	// counters hold their final value from the cycle after window_done
	always_ff @(posedge intclk) begin
		if (state == corr_pkg::header) begin
			words <= word_bus;
		end
	end

	// ##########################################################
	// FSM
	// ##########################################################
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= corr_pkg::idle;
			byte_idx <= '0;
			chk <= '0;
		end else if (abort) begin
			state <= corr_pkg::idle;
		end else begin
			case (state)
				corr_pkg::idle: begin
					byte_idx <= '0;
					chk <= '0;
					if (window_done) state <= corr_pkg::header;
				end
				corr_pkg::header: begin
					chk <= chk ^ tx_data;
					state <= corr_pkg::divisor;
				end
				corr_pkg::divisor: begin
					chk <= chk ^ tx_data;
					state <= corr_pkg::payload;
				end
				corr_pkg::payload: begin
					chk <= chk ^ tx_data;
					byte_idx <= byte_idx + 6'd1;
					if (byte_idx == 6'(corr_pkg::packet_bytes - 4)) begin  // last payload byte
						state <= corr_pkg::checksum;
					end
				end
				default: state <= corr_pkg::idle;  // checksum sent
			endcase
		end
	end

	// ##########################################################
	// byte mux
	// ##########################################################
	assign cur_word = words[byte_idx[5:1]];
	assign tx_valid = (state != corr_pkg::idle);

	always_comb begin
		case (state)
			corr_pkg::header: tx_data = corr_pkg::sync_byte;
			corr_pkg::divisor: tx_data = {3'b000, cfg.div_code};
			corr_pkg::payload: tx_data = byte_idx[0] ? cur_word[7:0] : cur_word[15:8];
			corr_pkg::checksum: tx_data = chk;
			default: tx_data = 8'h00;
		endcase
	end

	assert property (@(posedge intclk) disable iff (!rst_n)
		state == corr_pkg::idle |-> !tx_valid);

	// a finished window always finds the framer free
	assert property (@(posedge intclk) disable iff (!rst_n)
		window_done |-> state == corr_pkg::idle);

endmodule

// ==== src/correlator_top.sv ====
// ##########################################################
// four line intensity correlator, byte command in, byte
// packet out, both as one-cycle strobes
// ##########################################################

module correlator_top (
	input logic intclk,
	input logic rst_n,
	input logic [3:0] line_in,
	input logic [7:0] rx_data,
	input logic rx_valid,
	output logic [7:0] tx_data,
	output logic tx_valid,
	output logic busy
);

	corr_pkg::sample_cfg_t cfg;
	corr_pkg::window_ctl_t win;
	logic tick;
	logic window_active;
	logic window_done;
	logic [corr_pkg::num_ch-1:0] samples;
	logic [corr_pkg::num_ch-1:0][corr_pkg::num_lags-1:0] taps;
	logic [corr_pkg::num_ch-1:0][corr_pkg::count_w-1:0] pulse_counts;
	logic [corr_pkg::num_ch*corr_pkg::num_lags-1:0][corr_pkg::count_w-1:0] auto_counts;
	logic [corr_pkg::num_pairs-1:0][corr_pkg::count_w-1:0] cross_counts;

	assign busy = window_active | tx_valid;  // framer not idle

	cmd_parser parser_i (
		.intclk(intclk),
		.rst_n(rst_n),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.busy(busy),
		.cfg(cfg),
		.win(win)
	);

	sample_clock clock_i (
		.intclk(intclk),
		.rst_n(rst_n),
		.cfg(cfg),
		.win(win),
		.tick(tick),
		.window_active(window_active),
		.window_done(window_done)
	);

	// ##########################################################
	// detector channels
	// ##########################################################
	for (genvar c = 0; c < corr_pkg::num_ch; c++) begin : g_ch
		channel_frontend frontend_i (
			.intclk(intclk),
			.rst_n(rst_n),
			.line(line_in[c]),
			.invert(cfg.invert[c]),
			.tick(tick),
			.clear(win.start),
			.sample(samples[c]),
			.taps(taps[c]),
			.count(pulse_counts[c])
		);
	end

	lag_correlator correlator_i (
		.intclk(intclk),
		.rst_n(rst_n),
		.tick(tick),
		.clear(win.start),
		.samples(samples),
		.taps(taps),
		.auto_counts(auto_counts),
		.cross_counts(cross_counts)
	);

	packet_framer framer_i (
		.intclk(intclk),
		.rst_n(rst_n),
		.window_done(window_done),
		.abort(win.abort),
		.cfg(cfg),
		.pulse_counts(pulse_counts),
		.auto_counts(auto_counts),
		.cross_counts(cross_counts),
		.tx_data(tx_data),
		.tx_valid(tx_valid)
	);

endmodule

// ==== verification/correlator_tb.sv ====
// ##########################################################
// directed tests for correlator_top, lines held constant per
// window, expected packets from a count model of the levels
// ##########################################################

module correlator_tb;

	logic intclk;
	logic rst_n;
	logic [3:0] line_in;
	logic [7:0] rx_data;
	logic rx_valid;
	logic [7:0] tx_data;
	logic tx_valid;
	logic busy;

	logic [7:0] expected_pkt [corr_pkg::packet_bytes];
	logic [7:0] got_pkt [corr_pkg::packet_bytes];
	int errors;
	int tests_run;
	int tests_failed;

	correlator_top dut_i (
		.intclk(intclk),
		.rst_n(rst_n),
		.line_in(line_in),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.busy(busy)
	);

	initial begin
		intclk = 1'b0;
		forever #5 intclk = ~intclk;
	end

	// ##########################################################
	// helpers
	// ##########################################################
	task automatic next_cycle();
		@(posedge intclk);
		#1;  // drive and sample just after the edge
	endtask

	task automatic send_cmd(input corr_pkg::opcode_e op, input logic [4:0] arg);
		rx_data = {op, arg};
		rx_valid = 1'b1;
		next_cycle();
		rx_valid = 1'b0;
		rx_data = 8'h00;
	endtask

	// levels are after inversion, n ticks in the window
	task automatic build_expected(input logic [3:0] lv, input int n, input logic [4:0] div_code);
		logic [15:0] words [18];
		logic [7:0] chk;
		int w;
		w = 0;
		for (int c = 0; c < 4; c++) begin
			words[w] = lv[c] ? 16'(n) : 16'd0;
			w++;
		end
		for (int c = 0; c < 4; c++) begin
			for (int k = 1; k <= 2; k++) begin
				words[w] = lv[c] ? 16'(n - k) : 16'd0;  // first k ticks see zero taps
				w++;
			end
		end
		for (int a = 0; a < 4; a++) begin
			for (int b = a + 1; b < 4; b++) begin
				words[w] = (lv[a] && lv[b]) ? 16'(n) : 16'd0;
				w++;
			end
		end
		expected_pkt[0] = 8'hA5;
		expected_pkt[1] = {3'b000, div_code};
		for (int i = 0; i < 18; i++) begin
			expected_pkt[2 + 2 * i] = words[i][15:8];
			expected_pkt[3 + 2 * i] = words[i][7:0];
		end
		chk = 8'h00;
		for (int i = 0; i < 38; i++) begin
			chk = chk ^ expected_pkt[i];
		end
		expected_pkt[38] = chk;
	endtask

	task automatic collect_packet(input int limit, output bit ok);
		int waited;
		waited = 0;
		ok = 1'b0;
		while (tx_valid !== 1'b1 && waited < limit) begin
			next_cycle();
			waited++;
		end
		if (tx_valid !== 1'b1) begin
			$display("timeout, no packet started within %0d cycles", limit);
			errors++;
		end else begin
			ok = 1'b1;
			for (int i = 0; i < corr_pkg::packet_bytes; i++) begin
				if (tx_valid !== 1'b1) begin
					$display("Error at %0t: tx_valid byte %0d got %b expected 1",
						$time, i, tx_valid);
					errors++;
					ok = 1'b0;
				end
				got_pkt[i] = tx_data;
				next_cycle();
			end
			if (tx_valid !== 1'b0 || busy !== 1'b0) begin
				$display("Error at %0t: tx_valid/busy got %b/%b expected 0/0",
					$time, tx_valid, busy);
				errors++;
			end
		end
	endtask

	task automatic compare_packet();
		for (int i = 0; i < corr_pkg::packet_bytes; i++) begin
			if (got_pkt[i] !== expected_pkt[i]) begin
				$display("Error at %0t: tx_data byte %0d got %02h expected %02h",
					$time, i, got_pkt[i], expected_pkt[i]);
				errors++;
			end
		end
	endtask

	task automatic run_window(input logic [4:0] div_code, input logic [3:0] mask,
			input logic [3:0] lines, input logic [4:0] len_code);
		bit ok;
		int n;
		n = (int'(len_code) + 1) * 8;
		send_cmd(corr_pkg::op_rate, div_code);
		send_cmd(corr_pkg::op_invert, {1'b0, mask});
		line_in = lines;
		send_cmd(corr_pkg::op_start, len_code);
		build_expected(lines ^ mask, n, div_code);
		collect_packet(n * (int'(div_code) + 1) + 10, ok);
		if (ok) begin
			compare_packet();
		end
	endtask

	task automatic report_result(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - errors_before);
		end
	endtask

	// ##########################################################
	// tests
	// ##########################################################
	task automatic check_idle_after_reset();
		int e0;
		e0 = errors;
		for (int i = 0; i < 50; i++) begin
			if (tx_valid !== 1'b0 || busy !== 1'b0) begin
				$display("Error at %0t: tx_valid/busy got %b/%b expected 0/0",
					$time, tx_valid, busy);
				errors++;
			end
			next_cycle();
		end
		report_result("idle after reset", e0);
	endtask

	task automatic check_all_high();
		int e0;
		e0 = errors;
		run_window(5'd0, 4'h0, 4'hF, 5'd0);  // 8 ticks, one per cycle
		report_result("all lines high", e0);
	endtask

	task automatic check_inverted_lines();
		int e0;
		e0 = errors;
		run_window(5'd2, 4'b0101, 4'b0011, 5'd1);  // levels 0110 after inversion
		run_window(5'd1, 4'b1111, 4'b0100, 5'd2);
		report_result("inverted lines", e0);
	endtask

	task automatic check_random_windows();
		int e0;
		e0 = errors;
		for (int i = 0; i < 5; i++) begin
			run_window(5'($urandom % 32), 4'($urandom % 16), 4'($urandom % 16),
				5'($urandom % 32));
		end
		report_result("random windows", e0);
	endtask

	task automatic check_start_while_busy();
		bit ok;
		int e0;
		e0 = errors;
		send_cmd(corr_pkg::op_rate, 5'd3);
		send_cmd(corr_pkg::op_invert, 5'd0);
		line_in = 4'hA;
		send_cmd(corr_pkg::op_start, 5'd0);
		repeat (5) next_cycle();
		if (busy !== 1'b1) begin
			$display("Error at %0t: busy got %b expected 1", $time, busy);
			errors++;
		end
		send_cmd(corr_pkg::op_start, 5'd5);  // must be dropped
		build_expected(4'hA, 8, 5'd3);
		collect_packet(8 * 4 + 10, ok);
		if (ok) begin
			compare_packet();
		end
		for (int i = 0; i < 250; i++) begin
			if (tx_valid !== 1'b0) begin
				$display("a second packet started after the start sent while busy");
				errors++;
				break;
			end
			next_cycle();
		end
		report_result("start while busy", e0);
	endtask

	task automatic check_clear_during_window();
		int e0;
		e0 = errors;
		send_cmd(corr_pkg::op_rate, 5'd0);
		send_cmd(corr_pkg::op_invert, 5'd0);
		line_in = 4'hF;
		send_cmd(corr_pkg::op_start, 5'd31);  // 256 ticks
		repeat (40) next_cycle();
		send_cmd(corr_pkg::op_clear, 5'd0);
		if (busy !== 1'b0 || tx_valid !== 1'b0) begin
			$display("Error at %0t: busy/tx_valid got %b/%b expected 0/0",
				$time, busy, tx_valid);
			errors++;
		end
		for (int i = 0; i < 300; i++) begin
			if (tx_valid !== 1'b0) begin
				$display("a packet was sent after the window was cleared");
				errors++;
				break;
			end
			next_cycle();
		end
		run_window(5'd0, 4'h0, 4'h5, 5'd0);
		report_result("clear during window", e0);
	endtask

	// ##########################################################
	// main sequence
	// ##########################################################
	initial begin
		rst_n = 1'b0;
		line_in = 4'h0;
		rx_data = 8'h00;
		rx_valid = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(32'h889e8818));
		repeat (10) @(posedge intclk);
		#1;
		rst_n = 1'b1;
		next_cycle();

		check_idle_after_reset();
		check_all_high();
		check_inverted_lines();
		check_random_windows();
		check_start_while_busy();
		check_clear_during_window();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== project.f ====
src/corr_pkg.sv
src/cmd_parser.sv
src/sample_clock.sv
src/channel_frontend.sv
src/lag_correlator.sv
src/packet_framer.sv
src/correlator_top.sv
verification/correlator_tb.sv

// ==== Makefile ====
TOP = correlator_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^=== PASS ===$$'

clean:
	rm -rf obj_dir
